// ==== include/ooo_defines.svh ====
// Sizing constants for the out-of-order integer core
// Data width, register count and queue depths

`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Datapath width in bits
`define OOO_XLEN 32

// Architectural registers x0..x31
`define OOO_NUM_REGS 32

// Reorder buffer entries, a power of two so the tag wraps by itself
`define OOO_ROB_DEPTH 8

// Reservation station slots
`define OOO_RS_SLOTS 4

// Instruction fetch queue entries, also a power of two
`define OOO_IFQ_DEPTH 4

`endif

// ==== src/ooo_pkg.sv ====
// Shared types of the out-of-order core
// Opcode, ALU operation and ROB state enums, tag and data types

`include "ooo_defines.svh"

package ooo_pkg;

    // RISC-V major opcodes kept by the core
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        ROB_EMPTY,
        ROB_ISSUED,  // Waiting for its CDB result
        ROB_DONE     // Result present, ready to commit
    } rob_state_e;

    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [`OOO_XLEN-1:0]              word_t;

endpackage

// ==== src/fetch_queue.sv ====
// Instruction fetch queue
// Circular FIFO between the instruction source and issue

`include "ooo_defines.svh"

module fetch_queue (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  ooo_pkg::word_t wr_instr,
    input  logic           rd_en,
    output ooo_pkg::word_t head_instr,
    output logic           empty,
    output logic           full
);

    localparam int DEPTH = `OOO_IFQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ooo_pkg::word_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign push = wr_en && !full;
    assign pop = rd_en && !empty;

    assign head_instr = mem[rd_ptr];  // Head shows the oldest entry
    assign empty = (count == '0);
    assign full = (count == (PTR_W+1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_instr;
    end

    // The source must hold off while the queue is full
    no_write_when_full_a: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else $error("fetch_queue written while full");

endmodule

// ==== src/issue_unit.sv ====
// In-order issue stage
// Decodes the queue head and decides whether it issues this cycle

module issue_unit (
    input  ooo_pkg::word_t    head_instr,
    input  logic              empty,
    input  logic              rob_full,
    input  logic              rs_full,
    output logic              issue,
    output ooo_pkg::reg_idx_t rs1,
    output ooo_pkg::reg_idx_t rs2,
    output ooo_pkg::reg_idx_t rd,
    output ooo_pkg::alu_op_e  alu_op,
    output logic              use_imm,
    output ooo_pkg::word_t    imm
);

    ooo_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic             funct7_alt;
    logic             legal;

    assign opcode = ooo_pkg::opcode_e'(head_instr[6:0]);
    assign funct3 = head_instr[14:12];
    assign funct7_alt = head_instr[30];  // Selects SUB over ADD

    assign rd = head_instr[11:7];
    assign rs1 = head_instr[19:15];
    assign use_imm = (opcode == ooo_pkg::OP_IMM);
    // No second source for ADDI, x0 keeps it from waiting on a tag
    assign rs2 = use_imm ? '0 : head_instr[24:20];
    assign imm = ooo_pkg::word_t'($signed(head_instr[31:20]));

    assign issue = !empty && !rob_full && !rs_full;

    always_comb begin
        alu_op = ooo_pkg::ALU_ADD;
        legal = 1'b0;
        case (opcode)
            ooo_pkg::OP_REG: begin
                legal = 1'b1;
                case (funct3)
                    3'b000: alu_op = funct7_alt ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
                    3'b100: alu_op = ooo_pkg::ALU_XOR;
                    3'b110: alu_op = ooo_pkg::ALU_OR;
                    3'b111: alu_op = ooo_pkg::ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            ooo_pkg::OP_IMM: legal = (funct3 == 3'b000);  // ADDI only
            default: legal = 1'b0;
        endcase
    end

    // Only OP and ADDI encodings may leave the queue
    legal_issue_a: assert final (!issue || legal)
        else $error("issued unsupported instruction %h", head_instr);

endmodule

// ==== src/register_status.sv ====
// Architectural register file with the register alias table
// Busy bit and producing ROB tag per register

`include "ooo_defines.svh"

module register_status (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    input  ooo_pkg::reg_idx_t rd,
    input  logic              rename_we,
    input  ooo_pkg::rob_tag_t rename_tag,
    input  logic              commit_valid,
    input  ooo_pkg::reg_idx_t commit_rd,
    input  ooo_pkg::rob_tag_t commit_tag,
    input  ooo_pkg::word_t    commit_value,
    output ooo_pkg::word_t    rs1_value,
    output ooo_pkg::word_t    rs2_value,
    output logic              rs1_busy,
    output logic              rs2_busy,
    output ooo_pkg::rob_tag_t rs1_tag,
    output ooo_pkg::rob_tag_t rs2_tag
);

    localparam int NREGS = `OOO_NUM_REGS;

    ooo_pkg::word_t    regs [NREGS];
    logic              busy [NREGS];
    ooo_pkg::rob_tag_t tags [NREGS];

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign rs1_busy = busy[rs1] && (rs1 != '0);  // x0 is never renamed
    assign rs2_busy = busy[rs2] && (rs2 != '0);
    assign rs1_tag = tags[rs1];
    assign rs2_tag = tags[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
                busy[i] <= 1'b0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                regs[commit_rd] <= commit_value;
                // Only the newest producer may release the mapping
                if (tags[commit_rd] == commit_tag) busy[commit_rd] <= 1'b0;
            end
            if (rename_we && rd != '0) busy[rd] <= 1'b1;  // Rename wins over a same-cycle clear
        end
    end

    always_ff @(posedge clk) begin
        if (rename_we && rd != '0) tags[rd] <= rename_tag;
    end

endmodule

// ==== src/reservation_station.sv ====
// Reservation station for the ALU
// Operand wakeup from the CDB and lowest-slot-first dispatch

`include "ooo_defines.svh"

module reservation_station (
    input  logic              clk,
    input  logic              rst,
    input  logic              write_en,
    input  ooo_pkg::alu_op_e  in_op,
    input  logic              in_use_imm,
    input  ooo_pkg::word_t    in_imm,
    input  ooo_pkg::word_t    in_vj,
    input  ooo_pkg::word_t    in_vk,
    input  logic              in_qj_wait,
    input  logic              in_qk_wait,
    input  ooo_pkg::rob_tag_t in_qj,
    input  ooo_pkg::rob_tag_t in_qk,
    input  ooo_pkg::rob_tag_t in_dest,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::word_t    cdb_value,
    output logic              full,
    output logic              dispatch_valid,
    output ooo_pkg::alu_op_e  dispatch_op,
    output ooo_pkg::word_t    dispatch_a,
    output ooo_pkg::word_t    dispatch_b,
    output ooo_pkg::rob_tag_t dispatch_dest
);

    localparam int SLOTS = `OOO_RS_SLOTS;
    localparam int IDX_W = $clog2(SLOTS);

    logic [SLOTS-1:0]  busy;
    logic [SLOTS-1:0]  ready;
    ooo_pkg::alu_op_e  op [SLOTS];
    logic              use_imm [SLOTS];
    ooo_pkg::word_t    imm [SLOTS];
    ooo_pkg::word_t    vj [SLOTS];
    ooo_pkg::word_t    vk [SLOTS];
    logic              qj_wait [SLOTS];
    logic              qk_wait [SLOTS];
    ooo_pkg::rob_tag_t qj [SLOTS];
    ooo_pkg::rob_tag_t qk [SLOTS];
    ooo_pkg::rob_tag_t dest [SLOTS];
    logic [IDX_W-1:0]  free_idx;
    logic [IDX_W-1:0]  sel_idx;

    // Downward scans so the lowest index is kept
    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            ready[i] = busy[i] && !qj_wait[i] && !qk_wait[i];
            if (!busy[i]) free_idx = IDX_W'(i);
            if (ready[i]) sel_idx = IDX_W'(i);
        end
    end

    assign full = &busy;
    assign dispatch_valid = |ready;
    assign dispatch_op = op[sel_idx];
    assign dispatch_a = vj[sel_idx];
    assign dispatch_b = use_imm[sel_idx] ? imm[sel_idx] : vk[sel_idx];
    assign dispatch_dest = dest[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (dispatch_valid) busy[sel_idx] <= 1'b0;  // Freed as it leaves
            if (write_en) busy[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            if (cdb_valid && qj_wait[i] && qj[i] == cdb_tag) begin
                vj[i] <= cdb_value;
                qj_wait[i] <= 1'b0;
            end
            if (cdb_valid && qk_wait[i] && qk[i] == cdb_tag) begin
                vk[i] <= cdb_value;
                qk_wait[i] <= 1'b0;
            end
        end
        if (write_en) begin
            op[free_idx] <= in_op;
            use_imm[free_idx] <= in_use_imm;
            imm[free_idx] <= in_imm;
            vj[free_idx] <= in_vj;
            vk[free_idx] <= in_vk;
            qj_wait[free_idx] <= in_qj_wait;
            qk_wait[free_idx] <= in_qk_wait;
            qj[free_idx] <= in_qj;
            qk[free_idx] <= in_qk;
            dest[free_idx] <= in_dest;
        end
    end

    no_write_when_full_a: assert property (@(posedge clk) disable iff (rst) write_en |-> !full)
        else $error("reservation station written while full");

endmodule

// ==== src/alu_unit.sv ====
// Two-stage ALU: execute register, then CDB broadcast register

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch_valid,
    input  ooo_pkg::alu_op_e  dispatch_op,
    input  ooo_pkg::word_t    dispatch_a,
    input  ooo_pkg::word_t    dispatch_b,
    input  ooo_pkg::rob_tag_t dispatch_dest,
    output logic              cdb_valid,
    output ooo_pkg::rob_tag_t cdb_tag,
    output ooo_pkg::word_t    cdb_value
);

    logic              ex_valid;
    ooo_pkg::alu_op_e  ex_op;
    ooo_pkg::word_t    ex_a;
    ooo_pkg::word_t    ex_b;
    ooo_pkg::rob_tag_t ex_dest;
    ooo_pkg::word_t    result;

    always_comb begin
        case (ex_op)
            ooo_pkg::ALU_SUB: result = ex_a - ex_b;
            ooo_pkg::ALU_AND: result = ex_a & ex_b;
            ooo_pkg::ALU_OR:  result = ex_a | ex_b;
            ooo_pkg::ALU_XOR: result = ex_a ^ ex_b;
            default:          result = ex_a + ex_b;  // ADD and ADDI
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            ex_valid <= dispatch_valid;
            cdb_valid <= ex_valid;
        end
    end

    // Payload pipeline
    always_ff @(posedge clk) begin
        ex_op <= dispatch_op;
        ex_a <= dispatch_a;
        ex_b <= dispatch_b;
        ex_dest <= dispatch_dest;
        cdb_tag <= ex_dest;
        cdb_value <= result;
    end

endmodule

// ==== src/reorder_buffer.sv ====
// Reorder buffer
// In-order allocation and commit, CDB completion and operand read ports

`include "ooo_defines.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::word_t    cdb_value,
    input  ooo_pkg::rob_tag_t read_tag1,
    input  ooo_pkg::rob_tag_t read_tag2,
    output ooo_pkg::rob_tag_t tail,
    output logic              full,
    output logic              read_done1,
    output logic              read_done2,
    output ooo_pkg::word_t    read_value1,
    output ooo_pkg::word_t    read_value2,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::rob_tag_t commit_tag,
    output ooo_pkg::word_t    commit_value
);

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    ooo_pkg::rob_state_e state [DEPTH];
    ooo_pkg::reg_idx_t   dest_rd [DEPTH];
    ooo_pkg::word_t      value [DEPTH];
    ooo_pkg::rob_tag_t   head;
    logic [CNT_W-1:0]    count;

    assign full = (count == CNT_W'(DEPTH));

    assign read_done1 = (state[read_tag1] == ooo_pkg::ROB_DONE);
    assign read_done2 = (state[read_tag2] == ooo_pkg::ROB_DONE);
    assign read_value1 = value[read_tag1];
    assign read_value2 = value[read_tag2];

    assign commit_valid = (state[head] == ooo_pkg::ROB_DONE);  // Head retires once done
    assign commit_rd = dest_rd[head];
    assign commit_tag = head;
    assign commit_value = value[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) state[i] <= ooo_pkg::ROB_EMPTY;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                state[tail] <= ooo_pkg::ROB_ISSUED;
                tail <= tail + 1'b1;
            end
            if (cdb_valid) state[cdb_tag] <= ooo_pkg::ROB_DONE;
            if (commit_valid) begin
                state[head] <= ooo_pkg::ROB_EMPTY;
                head <= head + 1'b1;
            end
            if (alloc && !commit_valid) count <= count + 1'b1;
            else if (commit_valid && !alloc) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) dest_rd[tail] <= alloc_rd;
        if (cdb_valid) value[cdb_tag] <= cdb_value;
    end

    // Each broadcast tag must name an entry still waiting for its result
    cdb_hits_issued_a: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> state[cdb_tag] == ooo_pkg::ROB_ISSUED)
        else $error("CDB completed ROB entry %0d in state %s", cdb_tag, state[cdb_tag].name());

endmodule

// ==== src/ooo_core.sv ====
// Tomasulo integer core top level
// Unit wiring and issue-time operand selection

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  ooo_pkg::word_t    instr,
    output logic              ifq_full,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value
);

    ooo_pkg::word_t    head_instr, imm, rs1_value, rs2_value;
    ooo_pkg::word_t    rob_value1, rob_value2, vj, vk;
    ooo_pkg::word_t    cdb_value, dispatch_a, dispatch_b;
    ooo_pkg::reg_idx_t rs1, rs2, rd;
    ooo_pkg::rob_tag_t rs1_tag, rs2_tag, rob_tail, commit_tag, cdb_tag, dispatch_dest;
    ooo_pkg::alu_op_e  alu_op, dispatch_op;
    logic              ifq_empty, issue, use_imm, rob_full, rs_full;
    logic              rs1_busy, rs2_busy, rob_done1, rob_done2, qj_wait, qk_wait;
    logic              cdb_valid, dispatch_valid;

    // Register file, done ROB entry, or the result on the CDB this cycle
    function automatic ooo_pkg::word_t pick_operand(input logic busy, input logic done,
            input ooo_pkg::word_t reg_val, input ooo_pkg::word_t rob_val,
            input ooo_pkg::word_t bus_val);
        if (!busy) return reg_val;
        if (done) return rob_val;
        return bus_val;  // Also harmless when the slot ends up waiting
    endfunction

    assign vj = pick_operand(rs1_busy, rob_done1, rs1_value, rob_value1, cdb_value);
    assign vk = pick_operand(rs2_busy, rob_done2, rs2_value, rob_value2, cdb_value);
    assign qj_wait = rs1_busy && !rob_done1 && !(cdb_valid && cdb_tag == rs1_tag);
    assign qk_wait = rs2_busy && !rob_done2 && !(cdb_valid && cdb_tag == rs2_tag);

    fetch_queue fetch_queue_inst (.clk, .rst, .wr_en(instr_valid), .wr_instr(instr),
        .rd_en(issue), .head_instr, .empty(ifq_empty), .full(ifq_full));

    issue_unit issue_unit_inst (.head_instr, .empty(ifq_empty), .rob_full, .rs_full,
        .issue, .rs1, .rs2, .rd, .alu_op, .use_imm, .imm);

    register_status register_status_inst (.clk, .rst, .rs1, .rs2, .rd, .rename_we(issue),
        .rename_tag(rob_tail), .commit_valid, .commit_rd, .commit_tag, .commit_value,
        .rs1_value, .rs2_value, .rs1_busy, .rs2_busy, .rs1_tag, .rs2_tag);

    reservation_station reservation_station_inst (.clk, .rst, .write_en(issue),
        .in_op(alu_op), .in_use_imm(use_imm), .in_imm(imm), .in_vj(vj), .in_vk(vk),
        .in_qj_wait(qj_wait), .in_qk_wait(qk_wait), .in_qj(rs1_tag), .in_qk(rs2_tag),
        .in_dest(rob_tail), .cdb_valid, .cdb_tag, .cdb_value, .full(rs_full),
        .dispatch_valid, .dispatch_op, .dispatch_a, .dispatch_b, .dispatch_dest);

    alu_unit alu_unit_inst (.clk, .rst, .dispatch_valid, .dispatch_op, .dispatch_a,
        .dispatch_b, .dispatch_dest, .cdb_valid, .cdb_tag, .cdb_value);

    reorder_buffer reorder_buffer_inst (.clk, .rst, .alloc(issue), .alloc_rd(rd),
        .cdb_valid, .cdb_tag, .cdb_value, .read_tag1(rs1_tag), .read_tag2(rs2_tag),
        .tail(rob_tail), .full(rob_full), .read_done1(rob_done1), .read_done2(rob_done2),
        .read_value1(rob_value1), .read_value2(rob_value2), .commit_valid, .commit_rd,
        .commit_tag, .commit_value);

endmodule

// ==== tests/ooo_core_tb.sv ====
// Testbench for the out-of-order integer core
// Reference register model, directed and random stimulus, commit checks

module ooo_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED = 24363;
    localparam int MAX_INSTR = 256;
    localparam int SEND_LIMIT = 200;   // Cycles a send may wait for room
    localparam int DRAIN_LIMIT = 400;

    // Instruction kinds of the reference model
    localparam int K_ADD = 0;
    localparam int K_SUB = 1;
    localparam int K_AND = 2;
    localparam int K_OR = 3;
    localparam int K_XOR = 4;
    localparam int K_ADDI = 5;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    ooo_pkg::word_t    instr;
    logic              ifq_full;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::word_t    commit_value;

    int          seed;
    string       test_name;
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [MAX_INSTR];
    logic [31:0] exp_value [MAX_INSTR];
    int          sent_count = 0;
    int          commit_count = 0;
    int          full_cycles = 0;

    ooo_core ooo_core_inst (.clk, .rst, .instr_valid, .instr, .ifq_full, .commit_valid,
        .commit_rd, .commit_value);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && commit_valid) commit_count <= commit_count + 1;
        if (!rst && ifq_full) full_cycles <= full_cycles + 1;  // Back-pressure seen
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expv,
            input logic [31:0] actv);
        stop_with_failure($sformatf("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
            test_name, field, expv, actv));
    endtask

    quiet_until_first_send_a: assert property (@(posedge clk) disable iff (rst)
        sent_count == 0 |-> !commit_valid && !ifq_full)
        else stop_with_failure("commit_valid or ifq_full rose before any instruction was sent");

    commit_expected_a: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_count < sent_count)
        else stop_with_failure("commit reported with no instruction outstanding");

    commit_rd_a: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd == exp_rd[commit_count])
        else report_mismatch("rd", $sampled(exp_rd[commit_count]), $sampled(commit_rd));

    commit_value_a: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_value == exp_value[commit_count])
        else report_mismatch("value", $sampled(exp_value[commit_count]),
            $sampled(commit_value));

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // RV32I encodings of the kept operations
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd, rs1, rs2,
            input logic [11:0] imm);
        case (kind)
            K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_ADDI:  return {imm, rs1, 3'b000, rd, 7'b0010011};
            default: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        endcase
    endfunction

    // Program-order execution against the model registers
    task automatic apply_model(input int kind, input logic [4:0] rd, rs1, rs2,
            input logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = model_regs[rs1];
        b = (kind == K_ADDI) ? {{20{imm[11]}}, imm} : model_regs[rs2];
        case (kind)
            K_SUB:   result = a - b;
            K_AND:   result = a & b;
            K_OR:    result = a | b;
            K_XOR:   result = a ^ b;
            default: result = a + b;
        endcase
        if (sent_count >= MAX_INSTR) stop_with_failure("too many instructions for the model");
        exp_rd[sent_count] = rd;
        exp_value[sent_count] = result;  // x0 commits still report the result
        sent_count++;
        if (rd != 5'd0) model_regs[rd] = result;
    endtask

    // Called at a rising edge; returns one edge after the strobe is driven
    task automatic send(input int kind, input logic [4:0] rd, rs1, rs2,
            input logic [11:0] imm);
        int waited;
        waited = 0;
        // ifq_full lags a strobe still in flight, so strobes never abut
        while (ifq_full || instr_valid) begin
            instr_valid <= 1'b0;
            @(posedge clk);
            waited++;
            if (waited > SEND_LIMIT) stop_with_failure("timed out waiting for ifq_full to drop");
        end
        instr_valid <= 1'b1;
        instr <= encode(kind, rd, rs1, rs2, imm);
        apply_model(kind, rd, rs1, rs2, imm);
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            instr_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        instr_valid <= 1'b0;
        @(posedge clk);
        while (commit_count != sent_count) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT)
                stop_with_failure($sformatf("timed out with %0d of %0d instructions committed",
                    commit_count, sent_count));
        end
    endtask

    initial begin
        logic [4:0] prev;
        logic [4:0] rd;
        int         start_full;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        seed = SEED;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_idle";
        idle(12);

        test_name = "independent_addi";
        for (int i = 0; i < 16; i++)
            send(K_ADDI, 5'(i + 1), (i < 8) ? 5'd0 : 5'(i - 7), 5'd0, 12'(rand_below(4096)));
        drain();

        // Gaps move the operand source between CDB, ROB and register file
        test_name = "dependent_chain";
        prev = 5'd1;
        for (int i = 0; i < 24; i++) begin
            rd = 5'(1 + rand_below(31));
            send(rand_below(6), rd, prev, 5'(rand_below(32)), 12'(rand_below(4096)));
            prev = rd;
            idle(rand_below(6));
        end
        drain();

        test_name = "random_mix";
        for (int i = 0; i < 64; i++) begin
            send(rand_below(6), 5'(rand_below(32)), 5'(rand_below(32)), 5'(rand_below(32)),
                12'(rand_below(4096)));
            idle(rand_below(3));
        end
        drain();

        test_name = "back_pressure";
        start_full = full_cycles;
        prev = 5'd2;
        for (int i = 0; i < 48; i++) begin
            rd = 5'(1 + rand_below(31));
            send(rand_below(6), rd, prev, prev, 12'(rand_below(4096)));
            prev = rd;
        end
        drain();
        if (full_cycles == start_full)
            stop_with_failure("ifq_full never rose during the back-pressure burst");

        test_name = "x0_writes";
        send(K_ADDI, 5'd0, 5'd0, 5'd0, 12'd5);
        send(K_ADD, 5'd0, 5'd3, 5'd4, 12'd0);
        send(K_XOR, 5'd0, 5'd5, 5'd6, 12'd0);
        send(K_ADD, 5'd6, 5'd0, 5'd0, 12'd0);
        send(K_ADDI, 5'd7, 5'd0, 5'd0, 12'hff9);
        send(K_SUB, 5'd8, 5'd0, 5'd7, 12'd0);
        send(K_OR, 5'd9, 5'd0, 5'd8, 12'd0);
        drain();

        idle(10);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
src/ooo_pkg.sv
src/fetch_queue.sv
src/issue_unit.sv
src/register_status.sv
src/reservation_station.sv
src/alu_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
tests/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - include
    files:
      - src/ooo_pkg.sv
      - src/fetch_queue.sv
      - src/issue_unit.sv
      - src/register_status.sv
      - src/reservation_station.sv
      - src/alu_unit.sv
      - src/reorder_buffer.sv
      - src/ooo_core.sv
  - target: test
    files:
      - tests/ooo_core_tb.sv
